//--- compile.f
src/cu_graph_pkg.sv
src/cu_input_stage.sv
src/vertex_job_dispatch.sv
src/vertex_unit.sv
src/job_counter_merge.sv
src/cu_output_stage.sv
src/cu_graph_control.sv
verif/tb_clock_gen.sv
verif/cu_graph_control_props.sv
verif/cu_graph_control_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the graph controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	-f compile.f --top-module cu_graph_control_tb

./obj_dir/Vcu_graph_control_tb +verilator+error+limit+1000 > sim.log
cat sim.log

if grep -qx "TEST PASS" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

//--- verif/cu_graph_control_tb.sv
// Testbench for the graph controller: reset, unconfigured hold, random jobs,
// disabled job burst and single-unit back-pressure

module cu_graph_control_tb import cu_graph_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int          WAIT_LIMIT  = 2000;
	localparam int          DRAIN_LIMIT = 4000;
	localparam logic [15:0] LFSR_TAPS   = 16'hB400;

	logic                        clock;
	logic                        rstn_input;
	logic                        enabled_in;
	logic [CONFIG_BITS-1:0]      cu_configure;
	logic                        vertex_job_valid;
	logic [VERTEX_SIZE_BITS-1:0] vertex_job_id;
	logic [EDGE_COUNT_BITS-1:0]  vertex_job_edges;
	logic                        vertex_job_request;
	logic [VERTEX_SIZE_BITS-1:0] vertex_job_counter_done;
	logic [EDGE_SIZE_BITS-1:0]   edge_job_counter_done;
	logic [15:0]                 lfsr = 16'd66;
	int unsigned                 timeouts = 0;
	int unsigned                 assert_failures;

	tb_clock_gen tb_clock_gen_inst (.clock(clock), .rstn_input(rstn_input));

	cu_graph_control #(
		.NUM_VERTEX_UNITS(DEFAULT_NUM_VERTEX_UNITS),
		.JOB_QUEUE_DEPTH (DEFAULT_JOB_QUEUE_DEPTH )
	) cu_graph_control_inst (
		.clock                  (clock                  ),
		.rstn_input             (rstn_input             ),
		.enabled_in             (enabled_in             ),
		.cu_configure           (cu_configure           ),
		.vertex_job_valid       (vertex_job_valid       ),
		.vertex_job_id          (vertex_job_id          ),
		.vertex_job_edges       (vertex_job_edges       ),
		.vertex_job_request     (vertex_job_request     ),
		.vertex_job_counter_done(vertex_job_counter_done),
		.edge_job_counter_done  (edge_job_counter_done  )
	);

	function automatic logic [15:0] next_lfsr(input logic [15:0] state);
		return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
	endfunction

	// One LFSR step per bit taken
	task automatic take_random_bits(input int count, output logic [31:0] value);
		value = '0;
		for (int b = 0; b < count; b++) begin
			lfsr  = next_lfsr(lfsr);
			value = {value[30:0], lfsr[0]};
		end
	endtask

	task automatic await_request(input logic level);
		int i;
		i = 0;
		while (vertex_job_request !== level && i < WAIT_LIMIT) begin
			@(negedge clock);
			i++;
		end
		if (vertex_job_request !== level) begin
			timeouts++;
			$display("Timeout at %0t: vertex_job_request never went to %0b", $time, level);
		end
	endtask

	task automatic let_jobs_drain();
		int i;
		i = 0;
		while (!cu_graph_control_inst.cu_graph_control_props_inst.drained && i < DRAIN_LIMIT) begin
			@(negedge clock);
			i++;
		end
		if (!cu_graph_control_inst.cu_graph_control_props_inst.drained) begin
			timeouts++;
			$display("Timeout at %0t: jobs still arriving, no idle stretch reached", $time);
		end
		repeat (2) @(negedge clock);
	endtask

	// Each job waits for the credit level before its pulse
	task automatic send_jobs(input int count, input int edge_bits,
			input logic [EDGE_COUNT_BITS-1:0] edge_base);
		logic [31:0] id_bits;
		logic [31:0] edge_draw;
		for (int n = 0; n < count; n++) begin
			await_request(1'b1);
			take_random_bits(16, id_bits);
			take_random_bits(edge_bits, edge_draw);
			vertex_job_valid = 1'b1;
			vertex_job_id    = id_bits;
			vertex_job_edges = edge_base | edge_draw[EDGE_COUNT_BITS-1:0];
			@(negedge clock);
			vertex_job_valid = 1'b0;
		end
	endtask

	initial begin
		int i;
		enabled_in       = 1'b0;
		cu_configure     = '0;
		vertex_job_valid = 1'b0;
		vertex_job_id    = '0;
		vertex_job_edges = '0;

		i = 0;
		while (rstn_input !== 1'b1 && i < WAIT_LIMIT) begin
			@(negedge clock);
			i++;
		end
		if (rstn_input !== 1'b1) begin
			timeouts++;
			$display("Timeout at %0t: reset was never released", $time);
		end
		repeat (4) @(negedge clock);

		// No mask yet, jobs must sit in the queue
		enabled_in = 1'b1;
		repeat (3) @(negedge clock);
		send_jobs(2, 4, '0);
		repeat (100) @(negedge clock);

		// All four units, then a zero word that leaves the mask alone
		cu_configure = CONFIG_BITS'(4'hF);
		@(negedge clock);
		cu_configure = '0;
		send_jobs(20, 5, '0);
		let_jobs_drain();

		// Burst while disabled is dropped
		enabled_in = 1'b0;
		repeat (3) @(negedge clock);
		send_jobs(6, 5, '0);
		enabled_in = 1'b1;
		repeat (3) @(negedge clock);
		send_jobs(5, 4, '0);
		let_jobs_drain();

		// One unit with long jobs
		cu_configure = CONFIG_BITS'(4'h4);
		@(negedge clock);
		cu_configure = '0;
		send_jobs(6, 6, 8'h80);
		await_request(1'b0);
		let_jobs_drain();

		assert_failures = cu_graph_control_inst.cu_graph_control_props_inst.failures;
		$display("Closing: %0d assertion failures, %0d timeouts", assert_failures, timeouts);
		if (assert_failures == 0 && timeouts == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

//--- verif/cu_graph_control_props.sv
// Bound checker for the graph controller
// Shadow job and edge counts from the top-level inputs
// Concurrent assertions on the outputs

module cu_graph_control_props import cu_graph_pkg::*; (
	input logic                        clock,
	input logic                        rstn_input,
	input logic                        enabled_in,
	input logic [CONFIG_BITS-1:0]      cu_configure,
	input logic                        vertex_job_valid,
	input logic [EDGE_COUNT_BITS-1:0]  vertex_job_edges,
	input logic                        vertex_job_request,
	input logic [VERTEX_SIZE_BITS-1:0] vertex_job_counter_done,
	input logic [EDGE_SIZE_BITS-1:0]   edge_job_counter_done
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int DRAIN_CYCLES = 1200;

	int unsigned                 failures = 0;
	logic                        clock_seen = 1'b0;
	logic                        rstn_prev = 1'b0;
	logic                        rst_meta;
	logic                        rst_sync;
	logic                        shadow_enabled;
	logic                        configured;
	int unsigned                 shadow_jobs;
	int unsigned                 shadow_edges;
	int                          idle_cycles;
	logic                        drained;
	logic [VERTEX_SIZE_BITS-1:0] vertex_done_prev;
	logic [EDGE_SIZE_BITS-1:0]   edge_done_prev;

	// Previous-cycle view of reset and totals
	always @(posedge clock) begin
		clock_seen       <= 1'b1;
		rstn_prev        <= rstn_input;
		vertex_done_prev <= vertex_job_counter_done;
		edge_done_prev   <= edge_job_counter_done;
	end

	// Same two-flop release as the input stage
	always_ff @(posedge clock or negedge rstn_input) begin
		if (!rstn_input) begin
			rst_meta <= 1'b0;
			rst_sync <= 1'b0;
		end else begin
			rst_meta <= 1'b1;
			rst_sync <= rst_meta;
		end
	end

	// A job counts only against the registered enable
	always_ff @(posedge clock or negedge rst_sync) begin
		if (!rst_sync) begin
			shadow_enabled <= 1'b0;
			configured     <= 1'b0;
			shadow_jobs    <= 0;
			shadow_edges   <= 0;
			idle_cycles    <= 0;
		end else begin
			shadow_enabled <= enabled_in;
			if (shadow_enabled && (|cu_configure))
				configured <= 1'b1;
			if (vertex_job_valid && shadow_enabled) begin
				shadow_jobs  <= shadow_jobs + 1;
				shadow_edges <= shadow_edges + 32'(vertex_job_edges);
				idle_cycles  <= 0;
			end else if (idle_cycles < DRAIN_CYCLES) begin
				idle_cycles <= idle_cycles + 1;
			end
		end
	end

	assign drained = (idle_cycles == DRAIN_CYCLES);

	////////////////////////////////////////////////////////////
	// Assertions
	////////////////////////////////////////////////////////////

	reset_request_low: assert property (@(posedge clock)
		(clock_seen && (!rstn_input || !rstn_prev)) |-> !vertex_job_request)
	else begin
		$error("** Error t=%0t vertex_job_request=%0b expected 0",
			$time, $sampled(vertex_job_request));
		failures++;
	end

	reset_totals_zero: assert property (@(posedge clock)
		(clock_seen && (!rstn_input || !rstn_prev)) |->
		(vertex_job_counter_done == '0 && edge_job_counter_done == '0))
	else begin
		$error("** Error t=%0t vertex_job_counter_done=%0d edge_job_counter_done=%0d expected 0",
			$time, $sampled(vertex_job_counter_done), $sampled(edge_job_counter_done));
		failures++;
	end

	unconfigured_totals_zero: assert property (@(posedge clock)
		disable iff (!rstn_input || !clock_seen)
		!configured |-> (vertex_job_counter_done == '0 && edge_job_counter_done == '0))
	else begin
		$error("** Error t=%0t vertex_job_counter_done=%0d edge_job_counter_done=%0d expected 0",
			$time, $sampled(vertex_job_counter_done), $sampled(edge_job_counter_done));
		failures++;
	end

	vertex_total_bounded: assert property (@(posedge clock)
		disable iff (!rstn_input || !clock_seen)
		vertex_job_counter_done <= shadow_jobs)
	else begin
		$error("** Error t=%0t vertex_job_counter_done=%0d limit %0d",
			$time, $sampled(vertex_job_counter_done), $sampled(shadow_jobs));
		failures++;
	end

	edge_total_bounded: assert property (@(posedge clock)
		disable iff (!rstn_input || !clock_seen)
		edge_job_counter_done <= shadow_edges)
	else begin
		$error("** Error t=%0t edge_job_counter_done=%0d limit %0d",
			$time, $sampled(edge_job_counter_done), $sampled(shadow_edges));
		failures++;
	end

	drained_vertex_match: assert property (@(posedge clock)
		disable iff (!rstn_input || !clock_seen)
		drained |-> (vertex_job_counter_done == shadow_jobs))
	else begin
		$error("** Error t=%0t vertex_job_counter_done=%0d expected %0d",
			$time, $sampled(vertex_job_counter_done), $sampled(shadow_jobs));
		failures++;
	end

	drained_edge_match: assert property (@(posedge clock)
		disable iff (!rstn_input || !clock_seen)
		drained |-> (edge_job_counter_done == shadow_edges))
	else begin
		$error("** Error t=%0t edge_job_counter_done=%0d expected %0d",
			$time, $sampled(edge_job_counter_done), $sampled(shadow_edges));
		failures++;
	end

	vertex_total_monotonic: assert property (@(posedge clock)
		disable iff (!rstn_input || !clock_seen)
		vertex_job_counter_done >= vertex_done_prev)
	else begin
		$error("** Error t=%0t vertex_job_counter_done=%0d was %0d",
			$time, $sampled(vertex_job_counter_done), $sampled(vertex_done_prev));
		failures++;
	end

	edge_total_monotonic: assert property (@(posedge clock)
		disable iff (!rstn_input || !clock_seen)
		edge_job_counter_done >= edge_done_prev)
	else begin
		$error("** Error t=%0t edge_job_counter_done=%0d was %0d",
			$time, $sampled(edge_job_counter_done), $sampled(edge_done_prev));
		failures++;
	end

endmodule

bind cu_graph_control cu_graph_control_props cu_graph_control_props_inst (
	.clock                  (clock                  ),
	.rstn_input             (rstn_input             ),
	.enabled_in             (enabled_in             ),
	.cu_configure           (cu_configure           ),
	.vertex_job_valid       (vertex_job_valid       ),
	.vertex_job_edges       (vertex_job_edges       ),
	.vertex_job_request     (vertex_job_request     ),
	.vertex_job_counter_done(vertex_job_counter_done),
	.edge_job_counter_done  (edge_job_counter_done  )
);

//--- verif/tb_clock_gen.sv
// Testbench clock source, 10 ns period
// Power-on reset held low for ten cycles

module tb_clock_gen (
	output logic clock,
	output logic rstn_input
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESET_CYCLES = 10;

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// Release away from the rising edge
	initial begin
		rstn_input = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		rstn_input = 1'b1;
	end

endmodule

//--- src/cu_graph_control.sv
// Graph compute unit controller top level
// Input stage, dispatch, vertex units, merge and output stage

module cu_graph_control import cu_graph_pkg::*; #(
	parameter int NUM_VERTEX_UNITS = DEFAULT_NUM_VERTEX_UNITS,
	parameter int JOB_QUEUE_DEPTH  = DEFAULT_JOB_QUEUE_DEPTH
) (
	input  logic                        clock,
	input  logic                        rstn_input,
	input  logic                        enabled_in,
	input  logic [CONFIG_BITS-1:0]      cu_configure,
	input  logic                        vertex_job_valid,
	input  logic [VERTEX_SIZE_BITS-1:0] vertex_job_id,
	input  logic [EDGE_COUNT_BITS-1:0]  vertex_job_edges,
	output logic                        vertex_job_request,
	output logic [VERTEX_SIZE_BITS-1:0] vertex_job_counter_done,
	output logic [EDGE_SIZE_BITS-1:0]   edge_job_counter_done
);

	logic                                             rstn_sync;
	logic                                             job_valid;
	logic [VERTEX_SIZE_BITS-1:0]                      job_id;
	logic [EDGE_COUNT_BITS-1:0]                       job_edges;
	logic [NUM_VERTEX_UNITS-1:0]                      unit_mask;
	logic [NUM_VERTEX_UNITS-1:0]                      unit_busy;
	logic [NUM_VERTEX_UNITS-1:0]                      unit_start;
	logic [NUM_VERTEX_UNITS-1:0][EDGE_COUNT_BITS-1:0] unit_edges;
	logic [NUM_VERTEX_UNITS-1:0]                      unit_finish;
	logic [NUM_VERTEX_UNITS-1:0][EDGE_COUNT_BITS-1:0] finish_edges;
	logic                                             request_next;
	logic [VERTEX_SIZE_BITS-1:0]                      vertex_total;
	logic [EDGE_SIZE_BITS-1:0]                        edge_total;

	////////////////////////////////////////////////////////////
	// Front end
	////////////////////////////////////////////////////////////

	// Enable level is consumed inside the input stage
	cu_input_stage #(.NUM_VERTEX_UNITS(NUM_VERTEX_UNITS)) cu_input_stage_inst (
		.clock           (clock           ),
		.rstn_input      (rstn_input      ),
		.enabled_in      (enabled_in      ),
		.cu_configure    (cu_configure    ),
		.vertex_job_valid(vertex_job_valid),
		.vertex_job_id   (vertex_job_id   ),
		.vertex_job_edges(vertex_job_edges),
		.rstn_sync       (rstn_sync       ),
		.enabled         (                ),
		.job_valid       (job_valid       ),
		.job_id          (job_id          ),
		.job_edges       (job_edges       ),
		.unit_mask       (unit_mask       )
	);

	vertex_job_dispatch #(
		.NUM_VERTEX_UNITS(NUM_VERTEX_UNITS),
		.JOB_QUEUE_DEPTH (JOB_QUEUE_DEPTH )
	) vertex_job_dispatch_inst (
		.clock             (clock       ),
		.rstn_sync         (rstn_sync   ),
		.job_valid         (job_valid   ),
		.job_id            (job_id      ),
		.job_edges         (job_edges   ),
		.unit_mask         (unit_mask   ),
		.unit_busy         (unit_busy   ),
		.unit_start        (unit_start  ),
		.unit_edges        (unit_edges  ),
		.vertex_job_request(request_next)
	);

	////////////////////////////////////////////////////////////
	// Vertex units
	////////////////////////////////////////////////////////////

	for (genvar i = 0; i < NUM_VERTEX_UNITS; i++) begin : gen_vertex_unit
		vertex_unit vertex_unit_inst (
			.clock       (clock          ),
			.rstn_sync   (rstn_sync      ),
			.start       (unit_start[i]  ),
			.edges       (unit_edges[i]  ),
			.busy        (unit_busy[i]   ),
			.finish      (unit_finish[i] ),
			.finish_edges(finish_edges[i])
		);
	end

	////////////////////////////////////////////////////////////
	// Back end
	////////////////////////////////////////////////////////////

	job_counter_merge #(.NUM_VERTEX_UNITS(NUM_VERTEX_UNITS)) job_counter_merge_inst (
		.clock       (clock       ),
		.rstn_sync   (rstn_sync   ),
		.finish      (unit_finish ),
		.finish_edges(finish_edges),
		.vertex_total(vertex_total),
		.edge_total  (edge_total  )
	);

	cu_output_stage cu_output_stage_inst (
		.clock                  (clock                  ),
		.rstn_sync              (rstn_sync              ),
		.request_next           (request_next           ),
		.vertex_total           (vertex_total           ),
		.edge_total             (edge_total             ),
		.vertex_job_request     (vertex_job_request     ),
		.vertex_job_counter_done(vertex_job_counter_done),
		.edge_job_counter_done  (edge_job_counter_done  )
	);

endmodule

//--- src/cu_output_stage.sv
// Output registers for the request level and the done totals

module cu_output_stage import cu_graph_pkg::*; (
	input  logic                        clock,
	input  logic                        rstn_sync,
	input  logic                        request_next,
	input  logic [VERTEX_SIZE_BITS-1:0] vertex_total,
	input  logic [EDGE_SIZE_BITS-1:0]   edge_total,
	output logic                        vertex_job_request,
	output logic [VERTEX_SIZE_BITS-1:0] vertex_job_counter_done,
	output logic [EDGE_SIZE_BITS-1:0]   edge_job_counter_done
);

	// All outputs read zero while in reset
	always_ff @(posedge clock or negedge rstn_sync) begin
		if (!rstn_sync) begin
			vertex_job_request      <= 1'b0;
			vertex_job_counter_done <= '0;
			edge_job_counter_done   <= '0;
		end else begin
			vertex_job_request      <= request_next;
			vertex_job_counter_done <= vertex_total;
			edge_job_counter_done   <= edge_total;
		end
	end

endmodule

//--- src/job_counter_merge.sv
// Completion merge: running totals of finished vertices and edges
// over all vertex units

module job_counter_merge import cu_graph_pkg::*; #(
	parameter int NUM_VERTEX_UNITS = DEFAULT_NUM_VERTEX_UNITS
) (
	input  logic                                             clock,
	input  logic                                             rstn_sync,
	input  logic [NUM_VERTEX_UNITS-1:0]                      finish,
	input  logic [NUM_VERTEX_UNITS-1:0][EDGE_COUNT_BITS-1:0] finish_edges,
	output logic [VERTEX_SIZE_BITS-1:0]                      vertex_total,
	output logic [EDGE_SIZE_BITS-1:0]                        edge_total
);

	logic [VERTEX_SIZE_BITS-1:0] vertex_inc;
	logic [EDGE_SIZE_BITS-1:0]   edge_inc;

	// Several units may finish in the same cycle
	always_comb begin
		vertex_inc = '0;
		edge_inc   = '0;
		for (int i = 0; i < NUM_VERTEX_UNITS; i++) begin
			if (finish[i]) begin
				vertex_inc = vertex_inc + 1'b1;
				edge_inc   = edge_inc + EDGE_SIZE_BITS'(finish_edges[i]);
			end
		end
	end

	always_ff @(posedge clock or negedge rstn_sync) begin
		if (!rstn_sync) begin
			vertex_total <= '0;
			edge_total   <= '0;
		end else begin
			vertex_total <= vertex_total + vertex_inc;
			edge_total   <= edge_total + edge_inc;
		end
	end

endmodule

//--- src/vertex_unit.sv
// Vertex unit: walks a job one edge per cycle,
// then pulses finish with the job's edge count

module vertex_unit import cu_graph_pkg::*; (
	input  logic                       clock,
	input  logic                       rstn_sync,
	input  logic                       start,
	input  logic [EDGE_COUNT_BITS-1:0] edges,
	output logic                       busy,
	output logic                       finish,
	output logic [EDGE_COUNT_BITS-1:0] finish_edges
);

	unit_state_t                state;
	logic [EDGE_COUNT_BITS-1:0] remaining;

	always_ff @(posedge clock or negedge rstn_sync) begin
		if (!rstn_sync) begin
			state     <= UNIT_IDLE;
			remaining <= '0;
		end else begin
			case (state)
				UNIT_IDLE: begin
					if (start) begin
						state     <= UNIT_BUSY;
						// Empty vertex still takes one cycle
						remaining <= (edges == '0) ? EDGE_COUNT_BITS'(1) : edges;
					end
				end
				UNIT_BUSY: begin
					remaining <= remaining - 1'b1;
					if (remaining == EDGE_COUNT_BITS'(1))
						state <= UNIT_DONE;
				end
				default: state <= UNIT_IDLE;
			endcase
		end
	end

	// Job edge count reported at completion
	always_ff @(posedge clock) begin
		if (start && (state == UNIT_IDLE))
			finish_edges <= edges;
	end

	// Done cycle still counts as busy
	assign busy   = (state != UNIT_IDLE);
	assign finish = (state == UNIT_DONE);

endmodule

//--- src/vertex_job_dispatch.sv
// Vertex job dispatch: circular job queue, credit request level
// and round-robin start of idle allowed vertex units

module vertex_job_dispatch import cu_graph_pkg::*; #(
	parameter int NUM_VERTEX_UNITS = DEFAULT_NUM_VERTEX_UNITS,
	parameter int JOB_QUEUE_DEPTH  = DEFAULT_JOB_QUEUE_DEPTH
) (
	input  logic                                             clock,
	input  logic                                             rstn_sync,
	input  logic                                             job_valid,
	input  logic [VERTEX_SIZE_BITS-1:0]                      job_id,
	input  logic [EDGE_COUNT_BITS-1:0]                       job_edges,
	input  logic [NUM_VERTEX_UNITS-1:0]                      unit_mask,
	input  logic [NUM_VERTEX_UNITS-1:0]                      unit_busy,
	output logic [NUM_VERTEX_UNITS-1:0]                      unit_start,
	output logic [NUM_VERTEX_UNITS-1:0][EDGE_COUNT_BITS-1:0] unit_edges,
	output logic                                             vertex_job_request
);

	localparam int PTR_BITS   = (JOB_QUEUE_DEPTH > 1) ? $clog2(JOB_QUEUE_DEPTH) : 1;
	localparam int COUNT_BITS = $clog2(JOB_QUEUE_DEPTH + 1);
	localparam int UNIT_BITS  = (NUM_VERTEX_UNITS > 1) ? $clog2(NUM_VERTEX_UNITS) : 1;
	localparam int ENTRY_BITS = VERTEX_SIZE_BITS + EDGE_COUNT_BITS;

	logic [ENTRY_BITS-1:0]       queue_mem [JOB_QUEUE_DEPTH];
	logic [PTR_BITS-1:0]         wr_ptr;
	logic [PTR_BITS-1:0]         rd_ptr;
	logic [COUNT_BITS-1:0]       count;
	logic [UNIT_BITS-1:0]        rr_ptr;
	logic [UNIT_BITS-1:0]        sel;
	logic                        sel_valid;
	logic                        pop;
	logic [NUM_VERTEX_UNITS-1:0] candidate;

	////////////////////////////////////////////////////////////
	// Unit selection
	////////////////////////////////////////////////////////////

	// A unit started last cycle has not raised busy yet
	assign candidate = unit_mask & ~unit_busy & ~unit_start;

	always_comb begin
		int unsigned idx;
		sel       = '0;
		sel_valid = 1'b0;
		for (int off = 0; off < NUM_VERTEX_UNITS; off++) begin
			idx = rr_ptr + off;
			if (idx >= NUM_VERTEX_UNITS)
				idx = idx - NUM_VERTEX_UNITS;
			if (!sel_valid && candidate[idx]) begin
				sel       = UNIT_BITS'(idx);
				sel_valid = 1'b1;
			end
		end
	end

	assign pop = sel_valid && (count != '0);

	// Credit level, slack covers jobs already on their way
	assign vertex_job_request = (JOB_QUEUE_DEPTH - int'(count)) > REQUEST_SLACK;

	////////////////////////////////////////////////////////////
	// Queue control
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn_sync) begin
		if (!rstn_sync) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			rr_ptr     <= '0;
			unit_start <= '0;
		end else begin
			unit_start <= '0;
			if (job_valid)
				wr_ptr <= (wr_ptr == PTR_BITS'(JOB_QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop) begin
				rd_ptr          <= (rd_ptr == PTR_BITS'(JOB_QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
				unit_start[sel] <= 1'b1;
				rr_ptr          <= (sel == UNIT_BITS'(NUM_VERTEX_UNITS - 1)) ? '0 : sel + 1'b1;
			end
			case ({job_valid, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Entry is {id, edges}; only the edge count leaves the queue
	always_ff @(posedge clock) begin
		if (job_valid)
			queue_mem[wr_ptr] <= {job_id, job_edges};
		if (pop)
			unit_edges[sel] <= queue_mem[rd_ptr][EDGE_COUNT_BITS-1:0];
	end

endmodule

//--- src/cu_input_stage.sv
// Input stage: reset synchronizer, enable register,
// gated vertex job capture and configuration mask hold

module cu_input_stage import cu_graph_pkg::*; #(
	parameter int NUM_VERTEX_UNITS = DEFAULT_NUM_VERTEX_UNITS
) (
	input  logic                        clock,
	input  logic                        rstn_input,
	input  logic                        enabled_in,
	input  logic [CONFIG_BITS-1:0]      cu_configure,
	input  logic                        vertex_job_valid,
	input  logic [VERTEX_SIZE_BITS-1:0] vertex_job_id,
	input  logic [EDGE_COUNT_BITS-1:0]  vertex_job_edges,
	output logic                        rstn_sync,
	output logic                        enabled,
	output logic                        job_valid,
	output logic [VERTEX_SIZE_BITS-1:0] job_id,
	output logic [EDGE_COUNT_BITS-1:0]  job_edges,
	output logic [NUM_VERTEX_UNITS-1:0] unit_mask
);

	logic rstn_meta;

	// Asynchronous assert, two-flop release
	always_ff @(posedge clock or negedge rstn_input) begin
		if (!rstn_input) begin
			rstn_meta <= 1'b0;
			rstn_sync <= 1'b0;
		end else begin
			rstn_meta <= 1'b1;
			rstn_sync <= rstn_meta;
		end
	end

	// Enable, job strobe and held mask
	always_ff @(posedge clock or negedge rstn_sync) begin
		if (!rstn_sync) begin
			enabled   <= 1'b0;
			job_valid <= 1'b0;
			unit_mask <= '0;
		end else begin
			enabled   <= enabled_in;
			job_valid <= vertex_job_valid & enabled;
			// A zero word leaves the previous mask in place
			if (enabled && (|cu_configure))
				unit_mask <= cu_configure[NUM_VERTEX_UNITS-1:0];
		end
	end

	// Payload follows the pins every cycle
	always_ff @(posedge clock) begin
		job_id    <= vertex_job_id;
		job_edges <= vertex_job_edges;
	end

endmodule

//--- src/cu_graph_pkg.sv
// Shared widths and defaults for the graph compute unit controller
// Vertex unit state encoding

package cu_graph_pkg;

	// Data path widths
	parameter int VERTEX_SIZE_BITS = 32;
	parameter int EDGE_SIZE_BITS   = 32;
	parameter int EDGE_COUNT_BITS  = 8;
	parameter int CONFIG_BITS      = 64;

	// Default sizing
	parameter int DEFAULT_NUM_VERTEX_UNITS = 4;
	parameter int DEFAULT_JOB_QUEUE_DEPTH  = 4;

	// Queue slots reserved for jobs already in flight
	// Output register, source and input register
	parameter int REQUEST_SLACK = 3;

	////////////////////////////////////////////////////////////
	// Vertex unit FSM states
	////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		UNIT_IDLE = 2'd0,
		UNIT_BUSY = 2'd1,
		UNIT_DONE = 2'd2
	} unit_state_t;

endpackage
